// ==== verif/armCoreStimulus.txt ====
# I <instruction word hex>, D <byte address hex> <data hex>
# S <expected store byte address hex> <expected store data hex>, in order
I E3A0A080
I E3A01005
I E2812003
I E0423001
I E202400C
I E1845003
I E1A06005
I E0867002
I E58A7000
I E58A5004
I E50A3004
I E3A09040
I E5998000
I E0888001
I E58A8008
I E599B004
I E58AB00C
I E519C004
I E58AC010
I E3510005
I 03A00001
I E58A0014
I 13A00002
I E58A0018
I E3510007
I B3A00003
I E58A001C
I A3A00004
I E58A0020
I E041D001
I 03A00005
I E58A0024
I EA000001
I E58A1028
I E58A202C
I E58A2030
I 0A000001
I E58A6034
I E58A7038
I EAFFFFFE
D 00000040 00001234
D 00000044 CAFE0000
D 0000003C 000055AA
S 00000080 00000013
S 00000084 0000000B
S 0000007C 00000003
S 00000088 00001239
S 0000008C CAFE0000
S 00000090 000055AA
S 00000094 00000001
S 00000098 00000001
S 0000009C 00000003
S 000000A0 00000003
S 000000A4 00000003
S 000000B0 00000008
S 000000B4 0000000B
S 000000B8 00000013

// ==== armCore.f ====
rtl/armIsaPkg.sv
rtl/armPipePkg.sv
rtl/armFetch.sv
rtl/armRegFile.sv
rtl/armDecode.sv
rtl/armExecute.sv
rtl/armMemWrite.sv
rtl/armHazard.sv
rtl/armCore.sv
verif/armCoreTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= armCoreTb
FILELIST ?= armCore.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@grep -q "PASS: all tests" $(LOG) || (echo "No pass message found"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/armCoreTb.sv ====
module armCoreTb;
        timeunit 1ns;
        timeprecision 100ps;

        localparam armPipePkg::wordT ResetVector = 32'h0000_0040;
        localparam int MemWords = 64;
        localparam int MaxStores = 64;
        // Program is placed at the word the reset vector points to
        localparam int ProgBase = ResetVector / 4;

        logic clk;
        logic rst;
        armPipePkg::wordT Instruction;
        armPipePkg::wordT ReadData;
        armPipePkg::wordT PC;
        armPipePkg::wordT ALUResult;
        armPipePkg::wordT WriteData;
        logic writeEnable;

        armPipePkg::wordT imem [0:MemWords-1];
        armPipePkg::wordT dmem [0:MemWords-1];
        armPipePkg::wordT expAddr [0:MaxStores-1];
        armPipePkg::wordT expData [0:MaxStores-1];

        int numWords;
        int numStores;
        int storeIdx;
        int cycleCount;
        int cycleLimit;
        int fd;
        int rc;
        string line;
        byte kind;
        armPipePkg::wordT fieldA;
        armPipePkg::wordT fieldB;

        armCore #(.resetVector(ResetVector)) i_armCore (
                .clk(clk),
                .rst(rst),
                .Instruction(Instruction),
                .ReadData(ReadData),
                .PC(PC),
                .ALUResult(ALUResult),
                .WriteData(WriteData),
                .writeEnable(writeEnable)
        );

        always #50 clk = ~clk;

        task automatic checkWord(string name, armPipePkg::wordT got, armPipePkg::wordT exp);
                if (got !== exp) begin
                        $display("MISMATCH time=%0t %s got=%h expected=%h",
                                 $time, name, got, exp);
                        $display("FAIL: see errors above");
                        $fatal(1);
                end
        endtask

        task automatic checkBit(string name, logic got, logic exp);
                if (got !== exp) begin
                        $display("MISMATCH time=%0t %s got=%b expected=%b",
                                 $time, name, got, exp);
                        $display("FAIL: see errors above");
                        $fatal(1);
                end
        endtask

        task automatic stopWith(string reason);
                $display("ERROR time=%0t %s", $time, reason);
                $display("FAIL: see errors above");
                $fatal(1);
        endtask

        // Synchronous instruction and data memories
        always @(posedge clk) begin
                Instruction <= imem[PC[7:2]];
                ReadData <= dmem[ALUResult[7:2]];
                if (!rst && writeEnable) begin
                        if (storeIdx >= numStores) begin
                                stopWith("store seen after the expected list was done");
                        end else begin
                                checkWord("ALUResult", ALUResult, expAddr[storeIdx]);
                                checkWord("WriteData", WriteData, expData[storeIdx]);
                                dmem[ALUResult[7:2]] = WriteData;
                                storeIdx++;
                        end
                end
        end

        always @(posedge clk) begin
                cycleCount++;
                if (cycleLimit > 0 && cycleCount > cycleLimit) begin
                        $display("Timeout after %0d cycles, %0d of %0d stores seen",
                                 cycleCount, storeIdx, numStores);
                        stopWith("expected stores are missing");
                end
        end

        initial begin
                clk = 1'b0;
                rst = 1'b1;
                Instruction = '0;
                ReadData = '0;
                numWords = 0;
                numStores = 0;
                storeIdx = 0;
                cycleCount = 0;
                cycleLimit = 0;
                for (int i = 0; i < MemWords; i++) begin
                        imem[i] = '0;
                        dmem[i] = 32'hA500_0000 ^ (i * 4);
                end

                fd = $fopen("verif/armCoreStimulus.txt", "r");
                if (fd == 0) begin
                        stopWith("cannot open the stimulus file");
                end
                while (!$feof(fd)) begin
                        line = "";
                        rc = $fgets(line, fd);
                        if (line.len() > 1 && line[0] != "#") begin
                                fieldA = '0;
                                fieldB = '0;
                                rc = $sscanf(line, "%c %h %h", kind, fieldA, fieldB);
                                if (kind == "I") begin
                                        imem[ProgBase + numWords] = fieldA;
                                        numWords++;
                                end else if (kind == "D") begin
                                        dmem[fieldA[7:2]] = fieldB;
                                end else if (kind == "S") begin
                                        expAddr[numStores] = fieldA;
                                        expData[numStores] = fieldB;
                                        numStores++;
                                end
                        end
                end
                $fclose(fd);
                cycleLimit = 20 * numWords + 100;

                repeat (3) @(posedge clk);
                rst <= 1'b0;

                // Reset state seen before the first fetch advances
                @(negedge clk);
                checkWord("PC", PC, ResetVector);
                checkBit("writeEnable", writeEnable, 1'b0);

                while (storeIdx < numStores) begin
                        @(posedge clk);
                end
                // Program spins on its final branch and must not store again
                repeat (8) @(posedge clk);

                $display("PASS: all tests");
                $finish;
        end

endmodule

// ==== rtl/armCore.sv ====
module armCore #(
        parameter armPipePkg::wordT resetVector = '0
) (
        input  logic              clk,
        input  logic              rst,
        input  armPipePkg::wordT  Instruction,
        input  armPipePkg::wordT  ReadData,
        output armPipePkg::wordT  PC,
        output armPipePkg::wordT  ALUResult,
        output armPipePkg::wordT  WriteData,
        output logic              writeEnable
);
        // Fetch and hazard
        armPipePkg::wordT instrD, pcPlus8D, branchTarget;
        logic validD, stall, flush, branchTaken;
        armPipePkg::fwdT fwdA, fwdB, fwdC;

        // Decode to execute
        armPipePkg::wordT opAE, opBE, opCE, immE;
        logic [3:0] rnE, rmE, rdE, rnD, rmD;
        armPipePkg::aluOpT aluOpE;
        armIsaPkg::condT condE;
        logic regWriteE, memWriteE, memToRegE, setFlagsE, aluSrcE, branchE;

        // Memory and writeback
        logic [3:0] execRn, execRm, execRd, rdM, rdW;
        armPipePkg::wordT aluResultM, writeDataM, memResult, wbResult;
        logic regWriteM, memWriteM, memToRegM, regWriteW, memToRegW;

        armFetch #(.resetVector(resetVector)) u_fetch (
                .clk(clk), .rst(rst), .stall(stall), .flush(flush),
                .branchTaken(branchTaken), .branchTarget(branchTarget),
                .Instruction(Instruction), .PC(PC), .instrD(instrD),
                .pcPlus8D(pcPlus8D), .validD(validD)
        );

        armDecode u_decode (
                .clk(clk), .rst(rst), .flush(flush), .stall(stall),
                .instrD(instrD), .pcPlus8D(pcPlus8D), .validD(validD),
                .wbRd(rdW), .wbWrite(regWriteW), .wbData(wbResult),
                .opAE(opAE), .opBE(opBE), .opCE(opCE), .immE(immE),
                .rnE(rnE), .rmE(rmE), .rdE(rdE), .aluOpE(aluOpE), .condE(condE),
                .regWriteE(regWriteE), .memWriteE(memWriteE), .memToRegE(memToRegE),
                .setFlagsE(setFlagsE), .aluSrcE(aluSrcE), .branchE(branchE),
                .rnD(rnD), .rmD(rmD)
        );

        armExecute u_execute (
                .clk(clk), .rst(rst),
                .opAE(opAE), .opBE(opBE), .opCE(opCE), .immE(immE),
                .rnE(rnE), .rmE(rmE), .rdE(rdE), .aluOpE(aluOpE), .condE(condE),
                .regWriteE(regWriteE), .memWriteE(memWriteE), .memToRegE(memToRegE),
                .setFlagsE(setFlagsE), .aluSrcE(aluSrcE), .branchE(branchE),
                .fwdA(fwdA), .fwdB(fwdB), .fwdC(fwdC),
                .memResult(memResult), .wbResult(wbResult),
                .branchTaken(branchTaken), .branchTarget(branchTarget),
                .execRn(execRn), .execRm(execRm), .execRd(execRd),
                .aluResultM(aluResultM), .writeDataM(writeDataM), .rdM(rdM),
                .regWriteM(regWriteM), .memWriteM(memWriteM), .memToRegM(memToRegM)
        );

        armMemWrite u_memWrite (
                .clk(clk), .rst(rst),
                .aluResultM(aluResultM), .writeDataM(writeDataM), .rdM(rdM),
                .regWriteM(regWriteM), .memWriteM(memWriteM), .memToRegM(memToRegM),
                .ReadData(ReadData), .ALUResult(ALUResult), .WriteData(WriteData),
                .writeEnable(writeEnable), .memResult(memResult), .rdW(rdW),
                .regWriteW(regWriteW), .memToRegW(memToRegW), .wbResult(wbResult)
        );

        armHazard u_hazard (
                .execRn(execRn), .execRm(execRm), .execRd(execRd),
                .rnD(rnD), .rmD(rmD),
                .rdM(rdM), .regWriteM(regWriteM), .memToRegM(memToRegM),
                .rdW(rdW), .regWriteW(regWriteW),
                .memToRegE(memToRegE), .branchTaken(branchTaken),
                .fwdA(fwdA), .fwdB(fwdB), .fwdC(fwdC),
                .stall(stall), .flush(flush)
        );

endmodule

// ==== rtl/armHazard.sv ====
module armHazard (
        input  logic [3:0]       execRn,
        input  logic [3:0]       execRm,
        input  logic [3:0]       execRd,
        input  logic [3:0]       rnD,
        input  logic [3:0]       rmD,
        input  logic [3:0]       rdM,
        input  logic             regWriteM,
        input  logic             memToRegM,
        input  logic [3:0]       rdW,
        input  logic             regWriteW,
        input  logic             memToRegE,
        input  logic             branchTaken,
        output armPipePkg::fwdT  fwdA,
        output armPipePkg::fwdT  fwdB,
        output armPipePkg::fwdT  fwdC,
        output logic             stall,
        output logic             flush
);
        // Memory stage wins, a load there has no data yet
        function automatic armPipePkg::fwdT pickSource(logic [3:0] src, logic [3:0] rdMem,
                                                       logic wrMem, logic ldMem,
                                                       logic [3:0] rdWb, logic wrWb);
                if (wrMem && !ldMem && rdMem == src) begin
                        return armPipePkg::fwdMem;
                end
                if (wrWb && rdWb == src) begin
                        return armPipePkg::fwdWb;
                end
                return armPipePkg::fwdReg;
        endfunction

        always_comb begin
                fwdA = pickSource(execRn, rdM, regWriteM, memToRegM, rdW, regWriteW);
                fwdB = pickSource(execRm, rdM, regWriteM, memToRegM, rdW, regWriteW);
                fwdC = pickSource(execRd, rdM, regWriteM, memToRegM, rdW, regWriteW);
                stall = memToRegE && (execRd == rnD || execRd == rmD);
                flush = branchTaken;
                assert (!(stall && flush));
        end

endmodule

// ==== rtl/armMemWrite.sv ====
module armMemWrite (
        input  logic              clk,
        input  logic              rst,
        input  armPipePkg::wordT  aluResultM,
        input  armPipePkg::wordT  writeDataM,
        input  logic [3:0]        rdM,
        input  logic              regWriteM,
        input  logic              memWriteM,
        input  logic              memToRegM,
        input  armPipePkg::wordT  ReadData,
        output armPipePkg::wordT  ALUResult,
        output armPipePkg::wordT  WriteData,
        output logic              writeEnable,
        output armPipePkg::wordT  memResult,
        output logic [3:0]        rdW,
        output logic              regWriteW,
        output logic              memToRegW,
        output armPipePkg::wordT  wbResult
);
        armPipePkg::wordT aluResultW;

        // Data memory port, address is the ALU result
        assign ALUResult = aluResultM;
        assign WriteData = writeDataM;
        assign writeEnable = memWriteM;
        assign memResult = aluResultM;

        always_ff @(posedge clk) begin
                if (rst) begin
                        regWriteW <= 1'b0;
                        memToRegW <= 1'b0;
                end else begin
                        regWriteW <= regWriteM;
                        memToRegW <= memToRegM;
                end
                aluResultW <= aluResultM;
                rdW <= rdM;
        end

        // Load data arrives one cycle after the address
        assign wbResult = memToRegW ? ReadData : aluResultW;

        storeNotLoad: assert property (@(posedge clk) disable iff (rst)
                !(memWriteM && memToRegM));

endmodule

// ==== rtl/armExecute.sv ====
module armExecute (
        input  logic                clk,
        input  logic                rst,
        input  armPipePkg::wordT    opAE,
        input  armPipePkg::wordT    opBE,
        input  armPipePkg::wordT    opCE,
        input  armPipePkg::wordT    immE,
        input  logic [3:0]          rnE,
        input  logic [3:0]          rmE,
        input  logic [3:0]          rdE,
        input  armPipePkg::aluOpT   aluOpE,
        input  armIsaPkg::condT     condE,
        input  logic                regWriteE,
        input  logic                memWriteE,
        input  logic                memToRegE,
        input  logic                setFlagsE,
        input  logic                aluSrcE,
        input  logic                branchE,
        input  armPipePkg::fwdT     fwdA,
        input  armPipePkg::fwdT     fwdB,
        input  armPipePkg::fwdT     fwdC,
        input  armPipePkg::wordT    memResult,
        input  armPipePkg::wordT    wbResult,
        output logic                branchTaken,
        output armPipePkg::wordT    branchTarget,
        output logic [3:0]          execRn,
        output logic [3:0]          execRm,
        output logic [3:0]          execRd,
        output armPipePkg::wordT    aluResultM,
        output armPipePkg::wordT    writeDataM,
        output logic [3:0]          rdM,
        output logic                regWriteM,
        output logic                memWriteM,
        output logic                memToRegM
);
        armPipePkg::wordT srcA, srcB, storeData, bEff, result;
        armPipePkg::flagsT flagsQ, flagsNext;
        logic [32:0] sum;
        logic arith;
        logic pass;

        function automatic armPipePkg::wordT pickFwd(armPipePkg::fwdT sel, armPipePkg::wordT regVal,
                                                     armPipePkg::wordT memVal,
                                                     armPipePkg::wordT wbVal);
                case (sel)
                        armPipePkg::fwdMem: return memVal;
                        armPipePkg::fwdWb: return wbVal;
                        default: return regVal;
                endcase
        endfunction

        function automatic logic condPass(armIsaPkg::condT cond, armPipePkg::flagsT f);
                logic n, z, c, v;
                {n, z, c, v} = f;
                case (cond)
                        armIsaPkg::condEq: return z;
                        armIsaPkg::condNe: return !z;
                        armIsaPkg::condCs: return c;
                        armIsaPkg::condCc: return !c;
                        armIsaPkg::condMi: return n;
                        armIsaPkg::condPl: return !n;
                        armIsaPkg::condVs: return v;
                        armIsaPkg::condVc: return !v;
                        armIsaPkg::condHi: return c && !z;
                        armIsaPkg::condLs: return !c || z;
                        armIsaPkg::condGe: return n == v;
                        armIsaPkg::condLt: return n != v;
                        armIsaPkg::condGt: return !z && (n == v);
                        armIsaPkg::condLe: return z || (n != v);
                        armIsaPkg::condAl: return 1'b1;
                        default: return 1'b0;
                endcase
        endfunction

        always_comb begin
                srcA = pickFwd(fwdA, opAE, memResult, wbResult);
                srcB = aluSrcE ? immE : pickFwd(fwdB, opBE, memResult, wbResult);
                storeData = pickFwd(fwdC, opCE, memResult, wbResult);
                arith = (aluOpE == armPipePkg::aluAdd) || (aluOpE == armPipePkg::aluSub);
                // Subtract as A + ~B + 1, carry out is not-borrow
                bEff = (aluOpE == armPipePkg::aluSub) ? ~srcB : srcB;
                sum = {1'b0, srcA} + {1'b0, bEff} + {32'b0, aluOpE == armPipePkg::aluSub};
                case (aluOpE)
                        armPipePkg::aluAnd: result = srcA & srcB;
                        armPipePkg::aluOr: result = srcA | srcB;
                        default: result = sum[31:0];
                endcase
                flagsNext[3] = result[31];
                flagsNext[2] = result == '0;
                // No shifter, so logic ops keep C
                flagsNext[1] = arith ? sum[32] : flagsQ[1];
                flagsNext[0] = arith ? (srcA[31] == bEff[31]) && (result[31] != srcA[31])
                                     : flagsQ[0];
                pass = condPass(condE, flagsQ);
        end

        assign branchTaken = branchE && pass;
        assign branchTarget = result;
        assign execRn = rnE;
        assign execRm = rmE;
        assign execRd = rdE;

        always_ff @(posedge clk) begin
                if (rst) begin
                        flagsQ <= '0;
                end else if (setFlagsE && pass) begin
                        flagsQ <= flagsNext;
                end
        end

        // Failed condition turns the instruction into a bubble
        always_ff @(posedge clk) begin
                if (rst) begin
                        regWriteM <= 1'b0;
                        memWriteM <= 1'b0;
                        memToRegM <= 1'b0;
                end else begin
                        regWriteM <= regWriteE && pass;
                        memWriteM <= memWriteE && pass;
                        memToRegM <= memToRegE && pass;
                end
                aluResultM <= result;
                writeDataM <= storeData;
                rdM <= rdE;
        end

endmodule

// ==== rtl/armDecode.sv ====
module armDecode (
        input  logic                clk,
        input  logic                rst,
        input  logic                flush,
        input  logic                stall,
        input  armPipePkg::wordT    instrD,
        input  armPipePkg::wordT    pcPlus8D,
        input  logic                validD,
        input  logic [3:0]          wbRd,
        input  logic                wbWrite,
        input  armPipePkg::wordT    wbData,
        output armPipePkg::wordT    opAE,
        output armPipePkg::wordT    opBE,
        output armPipePkg::wordT    opCE,
        output armPipePkg::wordT    immE,
        output logic [3:0]          rnE,
        output logic [3:0]          rmE,
        output logic [3:0]          rdE,
        output armPipePkg::aluOpT   aluOpE,
        output armIsaPkg::condT     condE,
        output logic                regWriteE,
        output logic                memWriteE,
        output logic                memToRegE,
        output logic                setFlagsE,
        output logic                aluSrcE,
        output logic                branchE,
        output logic [3:0]          rnD,
        output logic [3:0]          rmD
);
        armIsaPkg::instrU instr;
        armPipePkg::aluOpT aluOp;
        armPipePkg::wordT imm, rd1, rd2, rd3;
        logic regWrite, memWrite, memToReg, setFlags, aluSrc, branch, zeroA;

        assign instr = instrD;

        always_comb begin
                regWrite = 1'b0;
                memWrite = 1'b0;
                memToReg = 1'b0;
                setFlags = 1'b0;
                aluSrc = 1'b1;
                branch = 1'b0;
                zeroA = 1'b0;
                aluOp = armPipePkg::aluAdd;
                imm = '0;
                rnD = instr.dpView.rn;
                // R15 as a source means no register
                rmD = 4'd15;
                case (instr.dpView.opClass)
                        2'b00: begin
                                aluSrc = instr.dpView.immBit;
                                imm = {24'b0, instr.dpView.operand2[7:0]};
                                if (!instr.dpView.immBit) begin
                                        rmD = instr.dpView.operand2[3:0];
                                end
                                regWrite = 1'b1;
                                setFlags = instr.dpView.setFlags;
                                case (instr.dpView.opcode)
                                        armIsaPkg::opAnd: aluOp = armPipePkg::aluAnd;
                                        armIsaPkg::opSub: aluOp = armPipePkg::aluSub;
                                        armIsaPkg::opAdd: aluOp = armPipePkg::aluAdd;
                                        armIsaPkg::opOrr: aluOp = armPipePkg::aluOr;
                                        armIsaPkg::opMov: begin
                                                // MOV is an OR with zero
                                                aluOp = armPipePkg::aluOr;
                                                zeroA = 1'b1;
                                                rnD = 4'd15;
                                        end
                                        armIsaPkg::opCmp: begin
                                                aluOp = armPipePkg::aluSub;
                                                regWrite = 1'b0;
                                                setFlags = 1'b1;
                                        end
                                        default: begin
                                                regWrite = 1'b0;
                                                setFlags = 1'b0;
                                        end
                                endcase
                        end
                        2'b01: begin
                                imm = instr.memView.up ? {20'b0, instr.memView.imm12}
                                                       : -{20'b0, instr.memView.imm12};
                                if (instr.memView.load) begin
                                        regWrite = 1'b1;
                                        memToReg = 1'b1;
                                end else begin
                                        memWrite = 1'b1;
                                        rmD = instr.memView.rd;
                                end
                        end
                        2'b10: begin
                                // Target is PC+8 plus the word offset
                                imm = {{6{instr.brView.imm24[23]}}, instr.brView.imm24, 2'b00};
                                branch = 1'b1;
                                rnD = 4'd15;
                        end
                        default: ;
                endcase
                if (instr.dpView.rd == 4'd15) begin
                        regWrite = 1'b0;
                        memToReg = 1'b0;
                end
        end

        armRegFile u_regFile (
                .clk     (clk),
                .rst     (rst),
                .ra1     (rnD),
                .ra2     (rmD),
                .ra3     (instr.dpView.rd),
                .wa      (wbRd),
                .we      (wbWrite),
                .wd      (wbData),
                .pcPlus8 (pcPlus8D),
                .rd1     (rd1),
                .rd2     (rd2),
                .rd3     (rd3)
        );

        always_ff @(posedge clk) begin
                if (rst || flush || stall || !validD) begin
                        regWriteE <= 1'b0;
                        memWriteE <= 1'b0;
                        memToRegE <= 1'b0;
                        setFlagsE <= 1'b0;
                        branchE <= 1'b0;
                end else begin
                        regWriteE <= regWrite;
                        memWriteE <= memWrite;
                        memToRegE <= memToReg;
                        setFlagsE <= setFlags;
                        branchE <= branch;
                end
                opAE <= zeroA ? '0 : rd1;
                opBE <= rd2;
                opCE <= rd3;
                immE <= imm;
                rnE <= rnD;
                rmE <= rmD;
                rdE <= instr.dpView.rd;
                aluOpE <= aluOp;
                aluSrcE <= aluSrc;
                condE <= instr.dpView.cond;
        end

endmodule

// ==== rtl/armRegFile.sv ====
module armRegFile (
        input  logic              clk,
        input  logic              rst,
        input  logic [3:0]        ra1,
        input  logic [3:0]        ra2,
        input  logic [3:0]        ra3,
        input  logic [3:0]        wa,
        input  logic              we,
        input  armPipePkg::wordT  wd,
        input  armPipePkg::wordT  pcPlus8,
        output armPipePkg::wordT  rd1,
        output armPipePkg::wordT  rd2,
        output armPipePkg::wordT  rd3
);
        // R0 to R14, R15 comes from the PC
        armPipePkg::wordT regs [0:14];

        function automatic armPipePkg::wordT readPort(logic [3:0] ra, armPipePkg::wordT stored);
                if (ra == 4'd15) begin
                        return pcPlus8;
                end
                // Same-cycle writeback is seen by decode
                if (we && wa == ra) begin
                        return wd;
                end
                return stored;
        endfunction

        always_ff @(posedge clk) begin
                if (rst) begin
                        for (int i = 0; i < 15; i++) begin
                                regs[i] <= '0;
                        end
                end else if (we && wa != 4'd15) begin
                        regs[wa] <= wd;
                end
        end

        always_comb begin
                rd1 = readPort(ra1, regs[ra1]);
                rd2 = readPort(ra2, regs[ra2]);
                rd3 = readPort(ra3, regs[ra3]);
        end

endmodule

// ==== rtl/armFetch.sv ====
module armFetch #(
        parameter armPipePkg::wordT resetVector = '0
) (
        input  logic              clk,
        input  logic              rst,
        input  logic              stall,
        input  logic              flush,
        input  logic              branchTaken,
        input  armPipePkg::wordT  branchTarget,
        input  armPipePkg::wordT  Instruction,
        output armPipePkg::wordT  PC,
        output armPipePkg::wordT  instrD,
        output armPipePkg::wordT  pcPlus8D,
        output logic              validD
);
        armPipePkg::wordT pcD;
        armPipePkg::wordT holdWord;
        logic useHold;

        always_ff @(posedge clk) begin
                if (rst) begin
                        PC <= resetVector;
                end else if (branchTaken) begin
                        PC <= branchTarget;
                end else if (!stall) begin
                        PC <= PC + 32'd4;
                end
        end

        // Memory returns the word one cycle late, so a stalled word is kept here
        always_ff @(posedge clk) begin
                if (rst || flush) begin
                        useHold <= 1'b0;
                        validD <= 1'b0;
                end else if (stall) begin
                        useHold <= 1'b1;
                end else begin
                        useHold <= 1'b0;
                        validD <= 1'b1;
                end
                if (stall) begin
                        holdWord <= instrD;
                end else begin
                        pcD <= PC;
                end
        end

        assign instrD = useHold ? holdWord : Instruction;
        assign pcPlus8D = pcD + 32'd8;

        pcAligned: assert property (@(posedge clk) disable iff (rst) PC[1:0] == 2'b00);

endmodule

// ==== rtl/armPipePkg.sv ====
package armPipePkg;

        typedef logic [31:0] wordT;

        // N Z C V from bit 3 down
        typedef logic [3:0] flagsT;

        typedef enum logic [1:0] {
                aluAdd,
                aluSub,
                aluAnd,
                aluOr
        } aluOpT;

        // Operand source in execute
        typedef enum logic [1:0] {
                fwdReg,
                fwdWb,
                fwdMem
        } fwdT;

endpackage

// ==== rtl/armIsaPkg.sv ====
package armIsaPkg;

        // Condition field in bits 31:28
        typedef enum logic [3:0] {
                condEq = 4'h0,
                condNe = 4'h1,
                condCs = 4'h2,
                condCc = 4'h3,
                condMi = 4'h4,
                condPl = 4'h5,
                condVs = 4'h6,
                condVc = 4'h7,
                condHi = 4'h8,
                condLs = 4'h9,
                condGe = 4'ha,
                condLt = 4'hb,
                condGt = 4'hc,
                condLe = 4'hd,
                condAl = 4'he
        } condT;

        // Supported data-processing opcodes only
        typedef enum logic [3:0] {
                opAnd = 4'h0,
                opSub = 4'h2,
                opAdd = 4'h4,
                opCmp = 4'ha,
                opOrr = 4'hc,
                opMov = 4'hd
        } dpOpT;

        typedef struct packed {
                condT        cond;
                logic [1:0]  opClass;
                logic        immBit;
                dpOpT        opcode;
                logic        setFlags;
                logic [3:0]  rn;
                logic [3:0]  rd;
                logic [11:0] operand2;
        } dpViewT;

        typedef struct packed {
                condT        cond;
                logic [1:0]  opClass;
                logic        immBit;
                logic        pre;
                logic        up;
                logic        byteBit;
                logic        writeBack;
                logic        load;
                logic [3:0]  rn;
                logic [3:0]  rd;
                logic [11:0] imm12;
        } memViewT;

        // Class is three bits here, 101 for B
        typedef struct packed {
                condT        cond;
                logic [2:0]  opClass;
                logic        link;
                logic [23:0] imm24;
        } brViewT;

        typedef union packed {
                dpViewT  dpView;
                memViewT memView;
                brViewT  brView;
        } instrU;

endpackage
